// File: include/sp_defs.svh
// Series processor shared sizes
// Residue width and number of elements in one job
`ifndef SP_DEFS_SVH
`define SP_DEFS_SVH

// One residue modulo 509
`define SP_ELEM_W 9

// Elements per job
`define SP_LEN 6

`endif

// File: hdl/sp_pkg.sv
// Series processor package
// Modulus, residue and series types, job mode and controller states
`default_nettype none

package sp_pkg;

`include "sp_defs.svh"

	// ========================================
	// Sizes and constants
	// ========================================
	localparam int ELEM_W = `SP_ELEM_W;
	localparam int LEN    = `SP_LEN;
	// Room for a product of two residues
	localparam int WIDE_W = 2 * ELEM_W;

	// The prime
	localparam logic [ELEM_W-1:0] MODULUS = 9'd509;
	// p - 2, Fermat inverse exponent
	localparam logic [ELEM_W-1:0] INV_EXP = 9'd507;

	// ========================================
	// Types
	// ========================================
	typedef logic [ELEM_W-1:0] elem_t;
	typedef logic [WIDE_W-1:0] wide_t;

	// Element 0 sits in the low bits
	typedef elem_t [LEN-1:0] series_t;

	// inv_en is bit 0
	typedef struct packed {
		logic sort_en;
		logic inv_en;
	} mode_t;

	// Controller steps of one job
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		INV,
		SORT,
		SUM,
		OUT
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/mod_reduce.sv
// Modulo 509 reducer
// Folds an 18-bit operand with 512 = 3 (mod 509), then trims it by
// repeated subtraction. Start/done handshake, 2 to 5 cycles
`default_nettype none

module mod_reduce (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          start,
	input  wire sp_pkg::wide_t operand,
	output logic               done,
	output sp_pkg::elem_t      residue
);

	// Largest fold is 511 + 3 * 511 = 2044
	localparam int ACC_W = 11;

	typedef enum logic [1:0] {
		RED_IDLE,
		RED_CALC,
		RED_DONE
	} red_state_e;

	red_state_e       state;
	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] fold;
	logic [ACC_W-1:0] trimmed;

	// ========================================
	// Datapath
	// ========================================

	// High nine bits weigh 512, three above the modulus
	assign fold = ACC_W'(operand[8:0]) + ACC_W'(operand[17:9]) * ACC_W'(3);

	// One subtraction step, holds once in range
	assign trimmed = (acc >= ACC_W'(sp_pkg::MODULUS)) ?
		acc - ACC_W'(sp_pkg::MODULUS) : acc;

	always_ff @(posedge clk) begin
		if (state == RED_IDLE && start) begin
			acc <= fold;
		end else if (state == RED_CALC) begin
			acc <= trimmed;
		end
	end

	// ========================================
	// Control
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RED_IDLE;
		end else begin
			case (state)
				RED_IDLE: begin
					if (start) begin
						state <= RED_CALC;
					end
				end
				// At most four subtractions after the fold
				RED_CALC: begin
					if (trimmed < ACC_W'(sp_pkg::MODULUS)) begin
						state <= RED_DONE;
					end
				end
				default: state <= RED_IDLE;
			endcase
		end
	end

	assign done    = (state == RED_DONE);
	// Upper accumulator bits are zero here
	assign residue = acc[8:0];

	// Callers issue the next start only after seeing done
	a_no_start_at_done: assert property (@(posedge clk) disable iff (!rst_n)
		!(start && done));

endmodule

`default_nettype wire

// File: hdl/mod_inverse.sv
// Modular inverse by Fermat, x^507 mod 509
// Square-and-multiply over the nine exponent bits, square and
// conditional product reduced in parallel on two reducers
`default_nettype none

module mod_inverse (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          start,
	input  wire sp_pkg::elem_t value,
	output logic               done,
	output sp_pkg::elem_t      result
);

	// Index of the top exponent bit
	localparam logic [3:0] LAST_BIT = 4'($bits(sp_pkg::elem_t) - 1);

	typedef enum logic [1:0] {
		INV_IDLE,
		INV_ISSUE,
		INV_WAIT,
		INV_DONE
	} inv_state_e;

	inv_state_e    state;
	logic [3:0]    bit_idx;
	logic          got_acc;
	logic          got_base;
	sp_pkg::elem_t acc;
	sp_pkg::elem_t base;
	logic          red_start;
	sp_pkg::wide_t acc_operand;
	sp_pkg::wide_t base_operand;
	logic          acc_done;
	logic          base_done;
	sp_pkg::elem_t acc_residue;
	sp_pkg::elem_t base_residue;

	// ========================================
	// Products for the current exponent bit
	// ========================================

	// Exponent bit clear keeps acc, sent through unchanged
	assign acc_operand = sp_pkg::INV_EXP[bit_idx] ?
		sp_pkg::wide_t'(acc) * sp_pkg::wide_t'(base) : sp_pkg::wide_t'(acc);
	assign base_operand = sp_pkg::wide_t'(base) * sp_pkg::wide_t'(base);
	assign red_start    = (state == INV_ISSUE);

	mod_reduce u_red_acc (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (red_start),
		.operand (acc_operand),
		.done    (acc_done),
		.residue (acc_residue)
	);

	mod_reduce u_red_base (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (red_start),
		.operand (base_operand),
		.done    (base_done),
		.residue (base_residue)
	);

	// Running product and power of x
	always_ff @(posedge clk) begin
		if (state == INV_IDLE && start) begin
			acc  <= sp_pkg::elem_t'(1);
			base <= value;
		end else begin
			if (acc_done) begin
				acc <= acc_residue;
			end
			if (base_done) begin
				base <= base_residue;
			end
		end
	end

	// ========================================
	// Step sequencing
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= INV_IDLE;
			bit_idx  <= '0;
			got_acc  <= 1'b0;
			got_base <= 1'b0;
		end else begin
			case (state)
				INV_IDLE: begin
					if (start) begin
						bit_idx <= '0;
						state   <= INV_ISSUE;
					end
				end
				INV_ISSUE: begin
					got_acc  <= 1'b0;
					got_base <= 1'b0;
					state    <= INV_WAIT;
				end
				// Reducers finish in any order
				INV_WAIT: begin
					if (acc_done) begin
						got_acc <= 1'b1;
					end
					if (base_done) begin
						got_base <= 1'b1;
					end
					if (got_acc && got_base) begin
						if (bit_idx == LAST_BIT) begin
							state <= INV_DONE;
						end else begin
							bit_idx <= bit_idx + 4'd1;
							state   <= INV_ISSUE;
						end
					end
				end
				default: state <= INV_IDLE;
			endcase
		end
	end

	assign done   = (state == INV_DONE);
	assign result = acc;

	// Every step left a fully reduced residue
	a_result_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (result < sp_pkg::MODULUS));

endmodule

`default_nettype wire

// File: hdl/sort6_net.sv
// Six-element ascending sorter
// Two three-element sorters, a registered merge column and two
// combinational clean-up columns; element 0 ends smallest
`default_nettype none

module sort6_net (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire sp_pkg::series_t values,
	output sp_pkg::series_t      sorted
);

	typedef sp_pkg::elem_t [2:0] trio_t;

	trio_t           low_half;
	trio_t           high_half;
	sp_pkg::series_t merge_q;
	sp_pkg::elem_t   mid_lo;
	sp_pkg::elem_t   mid_hi;

	// Three-element sort, index 0 smallest
	function automatic trio_t sort3(input sp_pkg::elem_t x0, input sp_pkg::elem_t x1,
			input sp_pkg::elem_t x2);
		sp_pkg::elem_t lo;
		sp_pkg::elem_t hi;
		sp_pkg::elem_t mid;
		trio_t         res;
		lo     = (x0 < x1) ? x0 : x1;
		hi     = (x0 < x1) ? x1 : x0;
		// Larger of the pair against the third
		mid    = (hi < x2) ? hi : x2;
		res[2] = (hi < x2) ? x2 : hi;
		res[0] = (lo < mid) ? lo : mid;
		res[1] = (lo < mid) ? mid : lo;
		return res;
	endfunction

	assign low_half  = sort3(values[0], values[1], values[2]);
	assign high_half = sort3(values[3], values[4], values[5]);

	// ========================================
	// Merge column, rank-wise min/max pairs
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			merge_q <= '0;
		end else begin
			for (int k = 0; k < 3; k++) begin
				merge_q[2*k]   <= (low_half[k] < high_half[k]) ? low_half[k] : high_half[k];
				merge_q[2*k+1] <= (low_half[k] < high_half[k]) ? high_half[k] : low_half[k];
			end
		end
	end

	// Ends are final after the merge
	assign sorted[0] = merge_q[0];
	assign sorted[5] = merge_q[5];

	// First clean-up column, pairs 1/2 and 3/4
	assign sorted[1] = (merge_q[1] < merge_q[2]) ? merge_q[1] : merge_q[2];
	assign mid_lo    = (merge_q[1] < merge_q[2]) ? merge_q[2] : merge_q[1];
	assign mid_hi    = (merge_q[3] < merge_q[4]) ? merge_q[3] : merge_q[4];
	assign sorted[4] = (merge_q[3] < merge_q[4]) ? merge_q[4] : merge_q[3];

	// Second column settles the middle pair
	assign sorted[2] = (mid_lo < mid_hi) ? mid_lo : mid_hi;
	assign sorted[3] = (mid_lo < mid_hi) ? mid_hi : mid_lo;

endmodule

`default_nettype wire

// File: hdl/series_sum.sv
// Series sum, e[i] = (a[i] + 2 b[i] + d[i]) mod 509
// Walks the six elements through one reducer and keeps the results
`default_nettype none

module series_sum (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            start,
	input  wire sp_pkg::series_t raw,
	input  wire sp_pkg::series_t inv,
	input  wire sp_pkg::series_t srt,
	output logic                 done,
	output sp_pkg::series_t      result
);

	typedef enum logic [1:0] {
		SUM_IDLE,
		SUM_ISSUE,
		SUM_WAIT,
		SUM_DONE
	} sum_state_e;

	sum_state_e    state;
	logic [2:0]    idx;
	logic          red_start;
	sp_pkg::wide_t red_operand;
	logic          red_done;
	sp_pkg::elem_t red_residue;

	// Four terms of up to 508, stays below 2048
	assign red_operand = sp_pkg::wide_t'(raw[idx]) + (sp_pkg::wide_t'(inv[idx]) << 1)
		+ sp_pkg::wide_t'(srt[idx]);
	assign red_start = (state == SUM_ISSUE);

	mod_reduce u_red (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (red_start),
		.operand (red_operand),
		.done    (red_done),
		.residue (red_residue)
	);

	always_ff @(posedge clk) begin
		if (state == SUM_WAIT && red_done) begin
			result[idx] <= red_residue;
		end
	end

	// ========================================
	// Element sequencing
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SUM_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				SUM_IDLE: begin
					if (start) begin
						idx   <= '0;
						state <= SUM_ISSUE;
					end
				end
				SUM_ISSUE: state <= SUM_WAIT;
				SUM_WAIT: begin
					if (red_done) begin
						if (idx == 3'd5) begin
							state <= SUM_DONE;
						end else begin
							idx   <= idx + 3'd1;
							state <= SUM_ISSUE;
						end
					end
				end
				default: state <= SUM_IDLE;
			endcase
		end
	end

	assign done = (state == SUM_DONE);

	// Controller holds the next job until this one is out
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> (state == SUM_IDLE));

endmodule

`default_nettype wire

// File: hdl/sp_ctrl.sv
// Series processor controller
// Captures the job and its mode, steps inversion, sort and sum,
// then serializes the six results one per cycle
`default_nettype none

module sp_ctrl (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            in_valid,
	input  wire sp_pkg::elem_t   in_data,
	input  wire sp_pkg::mode_t   in_mode,
	output logic                 inv_start,
	output sp_pkg::elem_t        inv_in,
	input  wire logic            inv_done,
	input  wire sp_pkg::elem_t   inv_out,
	output sp_pkg::series_t      b_series,
	input  wire sp_pkg::series_t d_sorted,
	output logic                 sum_start,
	output sp_pkg::series_t      raw_series,
	output sp_pkg::series_t      d_series,
	input  wire logic            sum_done,
	input  wire sp_pkg::series_t sum_result,
	output logic                 out_valid,
	output sp_pkg::elem_t        out_data
);

	sp_pkg::ctrl_state_e state;
	sp_pkg::ctrl_state_e state_next;
	sp_pkg::mode_t       mode;
	logic [2:0]          cnt;
	logic                step;
	logic                inv_wait;
	logic                sum_wait;
	logic                sort_phase;
	sp_pkg::series_t     d_reg;

	// ========================================
	// Step FSM
	// ========================================
	always_comb begin
		state_next = state;
		case (state)
			sp_pkg::IDLE: begin
				if (in_valid) begin
					state_next = sp_pkg::LOAD;
				end
			end
			// Sixth element picks the first enabled step
			sp_pkg::LOAD: begin
				if (in_valid && cnt == 3'd5) begin
					state_next = mode.inv_en ? sp_pkg::INV :
						(mode.sort_en ? sp_pkg::SORT : sp_pkg::SUM);
				end
			end
			sp_pkg::INV: begin
				if (inv_done && cnt == 3'd5) begin
					state_next = mode.sort_en ? sp_pkg::SORT : sp_pkg::SUM;
				end
			end
			// Second cycle has the registered sort output
			sp_pkg::SORT: begin
				if (sort_phase) begin
					state_next = sp_pkg::SUM;
				end
			end
			sp_pkg::SUM: begin
				if (sum_done) begin
					state_next = sp_pkg::OUT;
				end
			end
			sp_pkg::OUT: begin
				if (cnt == 3'd5) begin
					state_next = sp_pkg::IDLE;
				end
			end
			default: state_next = sp_pkg::IDLE;
		endcase
	end

	// Element counter advances on loads, inverses and outputs
	assign step = in_valid || (state == sp_pkg::INV && inv_done) || (state == sp_pkg::OUT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= sp_pkg::IDLE;
			mode       <= '0;
			cnt        <= '0;
			inv_wait   <= 1'b0;
			sum_wait   <= 1'b0;
			sort_phase <= 1'b0;
			out_valid  <= 1'b0;
			out_data   <= '0;
		end else begin
			state <= state_next;
			// Mode counts on the first element only
			if (state == sp_pkg::IDLE && in_valid) begin
				mode <= in_mode;
			end
			if (step) begin
				cnt <= (cnt == 3'd5) ? 3'd0 : cnt + 3'd1;
			end
			// One request in flight at a time
			if (inv_start) begin
				inv_wait <= 1'b1;
			end else if (inv_done) begin
				inv_wait <= 1'b0;
			end
			if (sum_start) begin
				sum_wait <= 1'b1;
			end else if (sum_done) begin
				sum_wait <= 1'b0;
			end
			sort_phase <= (state == sp_pkg::SORT) && !sort_phase;
			// Output register, zero between words
			out_valid <= (state == sp_pkg::OUT);
			out_data  <= (state == sp_pkg::OUT) ? sum_result[cnt] : '0;
		end
	end

	// ========================================
	// Series registers
	// ========================================
	always_ff @(posedge clk) begin
		if (in_valid) begin
			raw_series <= {in_data, raw_series[5:1]};
			b_series   <= {in_data, b_series[5:1]};
		end else if (state == sp_pkg::INV && inv_done) begin
			// Six rotations restore the input order
			b_series <= {inv_out, b_series[5:1]};
		end
		if (state == sp_pkg::SORT && sort_phase) begin
			d_reg <= d_sorted;
		end
	end

	assign inv_start = (state == sp_pkg::INV) && !inv_wait;
	assign inv_in    = b_series[0];
	assign sum_start = (state == sp_pkg::SUM) && !sum_wait;
	// Without sorting d is just b
	assign d_series  = mode.sort_en ? d_reg : b_series;

	// No new job until the sixth output
	a_in_valid_framing: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (state == sp_pkg::IDLE || state == sp_pkg::LOAD));

	// Fold and subtraction rely on residues below the modulus
	a_in_data_range: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (in_data < sp_pkg::MODULUS));

endmodule

`default_nettype wire

// File: hdl/sp_top.sv
// Series processor top
// Controller with the inverse, sorter and sum units around it
`default_nettype none

module sp_top (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          in_valid,
	input  wire sp_pkg::elem_t in_data,
	input  wire sp_pkg::mode_t in_mode,
	output logic               out_valid,
	output sp_pkg::elem_t      out_data
);

	logic            inv_start;
	sp_pkg::elem_t   inv_in;
	logic            inv_done;
	sp_pkg::elem_t   inv_out;
	sp_pkg::series_t b_series;
	sp_pkg::series_t d_sorted;
	logic            sum_start;
	sp_pkg::series_t raw_series;
	sp_pkg::series_t d_series;
	logic            sum_done;
	sp_pkg::series_t sum_result;

	sp_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_mode    (in_mode),
		.inv_start  (inv_start),
		.inv_in     (inv_in),
		.inv_done   (inv_done),
		.inv_out    (inv_out),
		.b_series   (b_series),
		.d_sorted   (d_sorted),
		.sum_start  (sum_start),
		.raw_series (raw_series),
		.d_series   (d_series),
		.sum_done   (sum_done),
		.sum_result (sum_result),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

	// One element at a time
	mod_inverse u_inv (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (inv_start),
		.value  (inv_in),
		.done   (inv_done),
		.result (inv_out)
	);

	// Sorts b continuously, sampled by the controller
	sort6_net u_sort (
		.clk    (clk),
		.rst_n  (rst_n),
		.values (b_series),
		.sorted (d_sorted)
	);

	series_sum u_sum (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (sum_start),
		.raw    (raw_series),
		.inv    (b_series),
		.srt    (d_series),
		.done   (sum_done),
		.result (sum_result)
	);

endmodule

`default_nettype wire

// File: dv/tb_sp.sv
// Series processor testbench
// Drives directed and random jobs into sp_top, predicts each result
// from the modulo 509 rules and checks every output word and its framing
`default_nettype none

module tb_sp;
	timeunit 1ns;
	timeprecision 100ps;

	// ========================================
	// Run constants
	// ========================================
	localparam int CLK_PERIOD      = 40;
	localparam int DRIVE_DELAY     = 5;
	localparam int RESET_CYCLES    = 10;
	localparam int RANDOM_JOBS     = 40;
	localparam int NUM_JOBS        = 4 + RANDOM_JOBS;
	localparam int CYCLES_PER_JOB  = 2000;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_JOBS * CYCLES_PER_JOB;
	localparam int SEED            = 39231;
	// Prime and Fermat exponent of the model
	localparam int PRIME     = 509;
	localparam int INV_POWER = 507;

	logic          clk;
	logic          rst_n;
	logic          in_valid;
	sp_pkg::elem_t in_data;
	sp_pkg::mode_t in_mode;
	logic          out_valid;
	sp_pkg::elem_t out_data;

	// Words still owed by the DUT, oldest first
	sp_pkg::elem_t expected_q[$];
	sp_pkg::elem_t exp_word;
	int            run_len;
	int            words_seen;
	int            jobs_sent;

	sp_top UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_mode   (in_mode),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Report the failure and stop the run
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "Run stopped on first error");
	endtask

	// ========================================
	// Reference model
	// ========================================

	// x^507 by plain repeated multiplication
	// Zero maps to zero
	function automatic int inverse_ref(input int x);
		int r;
		r = 1;
		for (int k = 0; k < INV_POWER; k++) begin
			r = (r * x) % PRIME;
		end
		return r;
	endfunction

	// e[i] = a[i] + 2 b[i] + d[i] mod 509
	function automatic sp_pkg::series_t expected_series(input sp_pkg::series_t raw,
			input sp_pkg::mode_t mode);
		int              a[6];
		int              b[6];
		int              d[6];
		int              tmp;
		sp_pkg::series_t e;
		for (int i = 0; i < 6; i++) begin
			a[i] = int'(raw[i]);
			b[i] = mode.inv_en ? inverse_ref(a[i]) : a[i];
			d[i] = b[i];
		end
		// Ascending bubble sort
		if (mode.sort_en) begin
			for (int p = 0; p < 5; p++) begin
				for (int j = 0; j < 5 - p; j++) begin
					if (d[j] > d[j+1]) begin
						tmp    = d[j];
						d[j]   = d[j+1];
						d[j+1] = tmp;
					end
				end
			end
		end
		for (int i = 0; i < 6; i++) begin
			e[i] = sp_pkg::elem_t'((a[i] + 2 * b[i] + d[i]) % PRIME);
		end
		return e;
	endfunction

	// Element 0 first in the argument list
	function automatic sp_pkg::series_t pack_series(input int v0, input int v1,
			input int v2, input int v3, input int v4, input int v5);
		sp_pkg::series_t s;
		s[0] = sp_pkg::elem_t'(v0);
		s[1] = sp_pkg::elem_t'(v1);
		s[2] = sp_pkg::elem_t'(v2);
		s[3] = sp_pkg::elem_t'(v3);
		s[4] = sp_pkg::elem_t'(v4);
		s[5] = sp_pkg::elem_t'(v5);
		return s;
	endfunction

	// ========================================
	// Stimulus
	// ========================================

	// Six back-to-back elements and a wait for the six results
	task automatic send_job(input sp_pkg::series_t raw, input sp_pkg::mode_t mode);
		sp_pkg::series_t expected;
		sp_pkg::mode_t   junk_mode;
		expected = expected_series(raw, mode);
		for (int i = 0; i < 6; i++) begin
			expected_q.push_back(expected[i]);
		end
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			// Mode only counts with the first element
			junk_mode = 2'($urandom);
			in_valid  = 1'b1;
			in_data   = raw[i];
			in_mode   = (i == 0) ? mode : junk_mode;
		end
		@(posedge clk);
		#(DRIVE_DELAY);
		in_valid  = 1'b0;
		in_data   = '0;
		in_mode   = '0;
		jobs_sent = jobs_sent + 1;
		wait (words_seen == 6 * jobs_sent);
	endtask

	initial begin
		sp_pkg::series_t rnd;
		sp_pkg::mode_t   rnd_mode;
		void'($urandom(SEED));
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_data    = '0;
		in_mode    = '0;
		run_len    = 0;
		words_seen = 0;
		jobs_sent  = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		repeat (3) @(posedge clk);

		// Sum only with values near the top of the range
		send_job(pack_series(508, 507, 0, 1, 255, 400), 2'b00);
		// Inversion with 0 and 1 as fixed points
		send_job(pack_series(0, 1, 2, 508, 100, 254), 2'b01);
		// Sort of a descending series with repeats
		send_job(pack_series(300, 300, 200, 100, 50, 7), 2'b10);
		// Inversion then sort
		send_job(pack_series(5, 508, 3, 3, 250, 1), 2'b11);

		// Back-to-back random jobs
		for (int n = 0; n < RANDOM_JOBS; n++) begin
			for (int i = 0; i < 6; i++) begin
				rnd[i] = sp_pkg::elem_t'($urandom_range(PRIME - 1, 0));
			end
			rnd_mode = 2'($urandom);
			send_job(rnd, rnd_mode);
		end

		repeat (4) @(posedge clk);
		if (expected_q.size() == 0 && run_len == 0) begin
			$display("No errors");
			$finish;
		end else begin
			abort_run("Results still outstanding at the end of the run");
		end
	end

	// ========================================
	// Output checks sampled mid-cycle
	// ========================================
	always @(negedge clk) begin
		if (!rst_n) begin
			assert (out_valid == 1'b0) else begin
				$display("FAIL out_valid expected %h actual %h", 1'b0, out_valid);
				abort_run("out_valid high during reset");
			end
		end else if (out_valid) begin
			assert (expected_q.size() > 0) else
				abort_run("out_valid raised with no result outstanding");
			exp_word = expected_q.pop_front();
			assert (out_data < sp_pkg::MODULUS) else
				abort_run("Result word not reduced below the modulus");
			assert (out_data == exp_word) else begin
				$display("FAIL out_data expected %h actual %h", exp_word, out_data);
				abort_run("Result word mismatch");
			end
			run_len    = run_len + 1;
			words_seen = words_seen + 1;
			assert (run_len <= 6) else
				abort_run("More than six consecutive out_valid cycles");
		end else begin
			// Idle output must read zero
			assert (out_data == '0) else begin
				$display("FAIL out_data expected %h actual %h", 9'h000, out_data);
				abort_run("out_data not zero while out_valid is low");
			end
			assert (run_len == 0 || run_len == 6) else
				abort_run("Output burst shorter than six words");
			run_len = 0;
		end
	end

	// Hang guard sized from the job count
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("Timeout: the DUT stopped producing results");
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hdl/sp_pkg.sv
hdl/mod_reduce.sv
hdl/mod_inverse.sv
hdl/sort6_net.sv
hdl/series_sum.sv
hdl/sp_ctrl.sv
hdl/sp_top.sv
dv/tb_sp.sv

// File: Makefile
# Verilator flow for the series processor
# The simulation exits non-zero when the testbench stops with $fatal

TOP = tb_sp

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
